//--- sample_buffer_params.svh
`ifndef SAMPLE_BUFFER_PARAMS_SVH
`define SAMPLE_BUFFER_PARAMS_SVH

// samples delivered per aclk word on each channel
`define SB_NSAMP 8

// bits per adc sample
`define SB_NBIT 12

// number of adc channels captured side by side
`define SB_NCHAN 2

// event ram address width, 64 memory words
`define SB_ADDR_W 6

// memory words written after the trigger, trigger word included
`define SB_POST_WORDS 40

// 1 turns on the 2-sample group scramble in the gearbox
// the mapping is only defined for 8 samples per aclk word
`define SB_SCRAMBLE 1

`endif

//--- sample_buffer_pkg.sv
`include "sample_buffer_params.svh"

package sample_buffer_pkg;

    // one channel's aclk word, sample 0 in the low bits
    typedef logic [`SB_NSAMP*`SB_NBIT-1:0] adc_word_t;

    // one channel's memclk word, 3/4 of an aclk word
    typedef logic [(`SB_NSAMP*3/4)*`SB_NBIT-1:0] mem_chan_t;

    // ram word, channel 0 in the low bits
    typedef struct packed {
        mem_chan_t [`SB_NCHAN-1:0] chan;
    } mem_word_t;

    // event ram address
    typedef logic [`SB_ADDR_W-1:0] addr_t;

    // capture state machine encoding
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ARMED = 2'd1,
        POST  = 2'd2,
        DONE  = 2'd3
    } capture_state_t;

    // status seen from outside the buffer
    typedef struct packed {
        logic  armed;
        logic  done;
        // oldest word once done, where readout starts
        addr_t stop_addr;
    } capture_status_t;

    // phase-zero strobes of the two clock domains
    typedef struct packed {
        logic aclk_sync;
        logic memclk_sync;
    } phase_sync_t;

endpackage

//--- transfer_phase_timer.sv
`timescale 1ns/100ps

module transfer_phase_timer (
    input  logic                           aclk_i,
    input  logic                           memclk_i,
    input  logic                           rst_i,
    output sample_buffer_pkg::phase_sync_t sync_o
);

    // 3 aclk cycles span the same time as 4 memclk cycles
    localparam int ACLK_PHASES   = 3;
    localparam int MEMCLK_PHASES = 4;

    logic [1:0] aclk_cnt;
    logic [1:0] memclk_cnt;

    // both counters sit at phase 0 while reset is held
    // release on a common edge keeps them aligned from then on
    always_ff @(posedge aclk_i) begin
        if (rst_i) begin
            aclk_cnt <= '0;
        end else if (aclk_cnt == 2'(ACLK_PHASES - 1)) begin
            aclk_cnt <= '0;
        end else begin
            aclk_cnt <= aclk_cnt + 2'd1;
        end
    end

    // mod-4 wraps by itself but the limit keeps the ratio explicit
    always_ff @(posedge memclk_i) begin
        if (rst_i) begin
            memclk_cnt <= '0;
        end else if (memclk_cnt == 2'(MEMCLK_PHASES - 1)) begin
            memclk_cnt <= '0;
        end else begin
            memclk_cnt <= memclk_cnt + 2'd1;
        end
    end

    // strobe marks the phase-zero cycle of each clock
    assign sync_o = '{aclk_sync: (aclk_cnt == '0), memclk_sync: (memclk_cnt == '0)};

    // a strobe in back-to-back cycles would break the gearbox buffer rotation
    a_aclk_sync_gap: assert property (@(posedge aclk_i) disable iff (rst_i)
        sync_o.aclk_sync |=> !sync_o.aclk_sync)
        else $error("aclk phase strobe in consecutive cycles");

    a_memclk_sync_gap: assert property (@(posedge memclk_i) disable iff (rst_i)
        sync_o.memclk_sync |=> !sync_o.memclk_sync)
        else $error("memclk phase strobe in consecutive cycles");

endmodule

//--- uram_sync_transfer.sv
`timescale 1ns/100ps
`include "sample_buffer_params.svh"

module uram_sync_transfer (
    input  logic                           aclk_i,
    input  logic                           memclk_i,
    input  sample_buffer_pkg::phase_sync_t sync_i,
    input  sample_buffer_pkg::adc_word_t   dat_i,
    output sample_buffer_pkg::mem_chan_t   dat_o
);

    localparam int NBIT = `SB_NBIT;
    // each aclk word is split at a different point per launch phase
    // a is bottom 2/top 6, b is bottom 6/top 2, c is bottom 4/top 4
    localparam int NSAMP_A_TOP = `SB_NSAMP*3/4;
    localparam int NSAMP_A_BOT = `SB_NSAMP*1/4;
    localparam int NSAMP_B_TOP = `SB_NSAMP*1/4;
    localparam int NSAMP_B_BOT = `SB_NSAMP*3/4;
    localparam int NSAMP_C_TOP = `SB_NSAMP*2/4;
    localparam int NSAMP_C_BOT = `SB_NSAMP*2/4;
    // scramble unit, 2 samples
    localparam int GW = 2*NBIT;
    localparam bit SCRAMBLE = (`SB_SCRAMBLE != 0);

    // one-hot aclk phase, rotates b, c, a
    logic [2:0] buffer_phase;
    // memclk phase, 1 after a sync
    logic [1:0] write_phase;
    // power-up lock tracking for the phase check, 2 means locked
    logic [1:0] lock_state = 2'd0;

    // buffers carry the name of their launch phase
    logic [NBIT*NSAMP_A_TOP-1:0] buf_a_top;
    logic [NBIT*NSAMP_A_BOT-1:0] buf_a_bot;
    logic [NBIT*NSAMP_B_TOP-1:0] buf_b_top;
    logic [NBIT*NSAMP_B_BOT-1:0] buf_b_bot;
    logic [NBIT*NSAMP_C_TOP-1:0] buf_c_top;
    logic [NBIT*NSAMP_C_BOT-1:0] buf_c_bot;

    sample_buffer_pkg::mem_chan_t write_data_in [4];

    // group order per write phase, g0 is the low 24 bits
    function automatic sample_buffer_pkg::mem_chan_t scramble(
        input logic [1:0] phase,
        input sample_buffer_pkg::mem_chan_t w
    );
        sample_buffer_pkg::mem_chan_t r;
        case (phase)
            // g0 and g1 trade places
            2'd0: r = {w[2*GW +: GW], w[0 +: GW], w[GW +: GW]};
            // full reversal
            2'd1: r = {w[0 +: GW], w[GW +: GW], w[2*GW +: GW]};
            2'd2: r = {w[GW +: GW], w[0 +: GW], w[2*GW +: GW]};
            default: r = w;
        endcase
        return SCRAMBLE ? r : w;
    endfunction

    // group mapping exists for 8 samples only
    if (`SB_NSAMP != 8) begin : g_nsamp_check
        $error("group scramble needs 8 samples per aclk word");
    end

    // the sync re-registered becomes the next phase bit
    // a stray sync upsets the rotation once, then it settles
    always_ff @(posedge aclk_i) begin
        buffer_phase <= {buffer_phase[1], sync_i.aclk_sync, buffer_phase[2]};
        if (buffer_phase[0]) begin
            buf_b_bot <= dat_i[0 +: NBIT*NSAMP_B_BOT];
            buf_b_top <= dat_i[NBIT*NSAMP_B_BOT +: NBIT*NSAMP_B_TOP];
        end
        if (buffer_phase[1]) begin
            buf_c_bot <= dat_i[0 +: NBIT*NSAMP_C_BOT];
            buf_c_top <= dat_i[NBIT*NSAMP_C_BOT +: NBIT*NSAMP_C_TOP];
        end
        if (buffer_phase[2]) begin
            buf_a_bot <= dat_i[0 +: NBIT*NSAMP_A_BOT];
            buf_a_top <= dat_i[NBIT*NSAMP_A_BOT +: NBIT*NSAMP_A_TOP];
        end
    end

    // stream order b bottom 6, b top 2 + c bottom 4, c top 4 + a bottom 2, a top 6
    assign write_data_in[0] = {buf_c_bot, buf_b_top};
    assign write_data_in[1] = {buf_a_bot, buf_c_top};
    assign write_data_in[2] = buf_a_top;
    assign write_data_in[3] = buf_b_bot;

    always_ff @(posedge memclk_i) begin
        dat_o <= scramble(write_phase, write_data_in[write_phase]);
        // memclk sync marks phase 0, so the next phase is 1
        if (sync_i.memclk_sync) begin
            write_phase <= 2'd1;
        end else begin
            write_phase <= write_phase + 2'd1;
        end
    end

    // a quiet cycle then a sync means the periodic sequence has started
    always_ff @(posedge memclk_i) begin
        if (lock_state == 2'd0 && !sync_i.memclk_sync) begin
            lock_state <= 2'd1;
        end else if (lock_state == 2'd1 && sync_i.memclk_sync) begin
            lock_state <= 2'd2;
        end
    end

    // timer and local phase counter must stay in step
    a_write_phase_lock: assert property (@(posedge memclk_i)
        (lock_state == 2'd2) && sync_i.memclk_sync |-> write_phase == 2'd0)
        else $error("memclk sync arrived outside write phase 0");

endmodule

//--- capture_fsm.sv
`timescale 1ns/100ps
`include "sample_buffer_params.svh"

module capture_fsm (
    input  logic                               memclk_i,
    input  logic                               rst_i,
    input  logic                               arm_i,
    input  logic                               trig_i,
    output logic                               wr_en_o,
    output sample_buffer_pkg::addr_t           wr_addr_o,
    output sample_buffer_pkg::capture_status_t status_o
);

    // trigger cycle writes the first post word, POST writes the rest
    localparam int POST_LOAD = `SB_POST_WORDS - 2;
    localparam int CNT_W = $clog2(`SB_POST_WORDS);

    sample_buffer_pkg::capture_state_t state;
    sample_buffer_pkg::addr_t          wr_addr;
    sample_buffer_pkg::addr_t          stop_addr;
    logic [CNT_W-1:0]                  post_cnt;
    logic                              armed;
    logic                              done;

    // ram takes a word every cycle while armed or counting down
    assign wr_en_o = (state == sample_buffer_pkg::ARMED) ||
                     (state == sample_buffer_pkg::POST);
    assign wr_addr_o = wr_addr;

    always_ff @(posedge memclk_i) begin
        if (rst_i) begin
            state     <= sample_buffer_pkg::IDLE;
            wr_addr   <= '0;
            stop_addr <= '0;
            post_cnt  <= '0;
            armed     <= 1'b0;
            done      <= 1'b0;
        end else begin
            // circular pointer, wraps at the ram depth
            if (wr_en_o) begin
                wr_addr <= wr_addr + 1'b1;
            end
            case (state)
                sample_buffer_pkg::IDLE, sample_buffer_pkg::DONE: begin
                    if (arm_i) begin
                        state <= sample_buffer_pkg::ARMED;
                        armed <= 1'b1;
                        done  <= 1'b0;
                    end
                end
                sample_buffer_pkg::ARMED: begin
                    if (trig_i) begin
                        state    <= sample_buffer_pkg::POST;
                        post_cnt <= CNT_W'(POST_LOAD);
                    end
                end
                sample_buffer_pkg::POST: begin
                    if (post_cnt == '0) begin
                        // last write this cycle, the next slot holds the oldest word
                        state     <= sample_buffer_pkg::DONE;
                        armed     <= 1'b0;
                        done      <= 1'b1;
                        stop_addr <= wr_addr + 1'b1;
                    end else begin
                        post_cnt <= post_cnt - 1'b1;
                    end
                end
                default: state <= sample_buffer_pkg::IDLE;
            endcase
        end
    end

    assign status_o = '{armed: armed, done: done, stop_addr: stop_addr};

    // armed flag is a separate register and must agree with the write enable
    a_no_write_idle: assert property (@(posedge memclk_i) disable iff (rst_i)
        !armed |-> !wr_en_o)
        else $error("ram write outside ARMED or POST");

    // done follows a write and the pointer parks on the stop address
    a_done_after_write: assert property (@(posedge memclk_i) disable iff (rst_i)
        $rose(done) |-> $past(wr_en_o) && (wr_addr == stop_addr))
        else $error("done without a final write at the stop address");

endmodule

//--- event_ram.sv
`timescale 1ns/100ps
`include "sample_buffer_params.svh"

module event_ram (
    input  logic                         memclk_i,
    input  logic                         wr_en_i,
    input  sample_buffer_pkg::addr_t     wr_addr_i,
    input  sample_buffer_pkg::mem_word_t wr_data_i,
    input  logic                         rd_en_i,
    input  sample_buffer_pkg::addr_t     rd_addr_i,
    output sample_buffer_pkg::mem_word_t rd_data_o
);

    localparam int DEPTH = 1 << `SB_ADDR_W;

    // both channels share one wide word per address
    sample_buffer_pkg::mem_word_t mem [DEPTH];

    // write port
    always_ff @(posedge memclk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, data one cycle after the enable
    // same-address read during a write returns the old word
    always_ff @(posedge memclk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

//--- sample_buffer_top.sv
`timescale 1ns/100ps
`include "sample_buffer_params.svh"

module sample_buffer_top (
    input  logic                               aclk_i,
    input  logic                               memclk_i,
    input  logic                               rst_i,
    input  sample_buffer_pkg::adc_word_t       dat_ch0_i,
    input  sample_buffer_pkg::adc_word_t       dat_ch1_i,
    input  logic                               arm_i,
    input  logic                               trig_i,
    input  logic                               rd_en_i,
    input  sample_buffer_pkg::addr_t           rd_addr_i,
    output sample_buffer_pkg::capture_status_t status_o,
    output sample_buffer_pkg::mem_word_t       rd_data_o
);

    sample_buffer_pkg::phase_sync_t                   phase_sync;
    sample_buffer_pkg::adc_word_t [`SB_NCHAN-1:0]     dat_chan;
    wire sample_buffer_pkg::mem_chan_t [`SB_NCHAN-1:0] chan_word;
    sample_buffer_pkg::mem_word_t                     wr_data;
    logic                                             wr_en;
    sample_buffer_pkg::addr_t                         wr_addr;

    // channel 0 in the low bits, same as the ram word
    assign dat_chan = {dat_ch1_i, dat_ch0_i};

    // shared phase strobes keep both gearboxes on the same write phase
    transfer_phase_timer transfer_phase_timer_i (
        .aclk_i   (aclk_i),
        .memclk_i (memclk_i),
        .rst_i    (rst_i),
        .sync_o   (phase_sync)
    );

    for (genvar g = 0; g < `SB_NCHAN; g++) begin : g_chan
        uram_sync_transfer uram_sync_transfer_i (
            .aclk_i   (aclk_i),
            .memclk_i (memclk_i),
            .sync_i   (phase_sync),
            .dat_i    (dat_chan[g]),
            .dat_o    (chan_word[g])
        );
    end

    assign wr_data = '{chan: chan_word};

    capture_fsm capture_fsm_i (
        .memclk_i  (memclk_i),
        .rst_i     (rst_i),
        .arm_i     (arm_i),
        .trig_i    (trig_i),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr),
        .status_o  (status_o)
    );

    event_ram event_ram_i (
        .memclk_i  (memclk_i),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en_i),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o)
    );

endmodule

//--- sample_buffer_tb.sv
`timescale 1ns/100ps
`include "sample_buffer_params.svh"

module sample_buffer_tb;

    localparam int ACLK_PERIOD   = 40;
    localparam int MEMCLK_PERIOD = 30;
    localparam int DRIVE_DELAY   = 2;
    localparam int RAM_WORDS     = 1 << `SB_ADDR_W;
    localparam int NBIT          = `SB_NBIT;
    localparam int WORD_SAMP     = `SB_NSAMP*3/4;

    // both clocks start high, first rising edges at 40 and 30 ns
    logic aclk   = 1'b1;
    logic memclk = 1'b1;
    logic rst;
    logic arm;
    logic trig;
    logic rd_en;
    sample_buffer_pkg::adc_word_t       dat_ch0;
    sample_buffer_pkg::adc_word_t       dat_ch1;
    sample_buffer_pkg::addr_t           rd_addr;
    sample_buffer_pkg::capture_status_t status;
    sample_buffer_pkg::mem_word_t       rd_data;

    // values taken from the stim file
    int aclk_words;
    int ramp_start;
    int ch1_offset;
    int arm_cycle;
    int trig_cycle;
    int exp_stop;
    int first_sample;
    int first_phase;
    bit stim_loaded = 1'b0;

    sample_buffer_top sample_buffer_top_i (
        .aclk_i    (aclk),
        .memclk_i  (memclk),
        .rst_i     (rst),
        .dat_ch0_i (dat_ch0),
        .dat_ch1_i (dat_ch1),
        .arm_i     (arm),
        .trig_i    (trig),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .status_o  (status),
        .rd_data_o (rd_data)
    );

    initial begin : aclk_gen
        forever begin
            #(ACLK_PERIOD/2) aclk = 1'b0;
            #(ACLK_PERIOD/2) aclk = 1'b1;
        end
    end

    initial begin : memclk_gen
        forever begin
            #(MEMCLK_PERIOD/2) memclk = 1'b0;
            #(MEMCLK_PERIOD/2) memclk = 1'b1;
        end
    end

    initial begin : input_init
        rst     = 1'b1;
        arm     = 1'b0;
        trig    = 1'b0;
        rd_en   = 1'b0;
        rd_addr = '0;
        dat_ch0 = '0;
        dat_ch1 = '0;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input logic [$bits(sample_buffer_pkg::mem_word_t)-1:0] got,
                               input logic [$bits(sample_buffer_pkg::mem_word_t)-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s, got %h expected %h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // next line that is neither blank nor a comment
    task automatic next_line(input int fd, output string line);
        line = "";
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                return;
            end
        end
        line = "";
    endtask

    task automatic load_stim();
        int    fd;
        string line;
        fd = $fopen("sample_buffer_stim.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file sample_buffer_stim.txt");
        end
        next_line(fd, line);
        if ($sscanf(line, "%d %d %h %d %d", aclk_words, ramp_start, ch1_offset,
                    arm_cycle, trig_cycle) != 5) begin
            abort_run("stimulus file: control line is malformed");
        end
        next_line(fd, line);
        if ($sscanf(line, "%d %d %d", exp_stop, first_sample, first_phase) != 3) begin
            abort_run("stimulus file: expectation line is malformed");
        end
        $fclose(fd);
    endtask

    // aclk word idx of the ramp, sample 0 in the low bits
    function automatic sample_buffer_pkg::adc_word_t ramp_word(input int idx, input int offset);
        sample_buffer_pkg::adc_word_t w;
        for (int s = 0; s < `SB_NSAMP; s++) begin
            w[s*NBIT +: NBIT] = NBIT'(ramp_start + idx*`SB_NSAMP + s + offset);
        end
        return w;
    endfunction

    // six stream samples from index first, then the 2-sample group order of the phase
    function automatic sample_buffer_pkg::mem_chan_t expected_chan(input int first,
                                                                   input int phase,
                                                                   input int offset);
        logic [2*NBIT-1:0] g [3];
        for (int j = 0; j < 3; j++) begin
            g[j] = {NBIT'(ramp_start + first + 2*j + 1 + offset),
                    NBIT'(ramp_start + first + 2*j + offset)};
        end
        if (`SB_SCRAMBLE == 0) begin
            return {g[2], g[1], g[0]};
        end
        case (phase)
            0: return {g[2], g[0], g[1]};
            1: return {g[0], g[1], g[2]};
            2: return {g[1], g[0], g[2]};
            default: return {g[2], g[1], g[0]};
        endcase
    endfunction

    // k counts from the oldest word, each one 6 samples and one phase further
    function automatic sample_buffer_pkg::mem_word_t expected_word(input int k);
        sample_buffer_pkg::mem_word_t w;
        w.chan[0] = expected_chan(first_sample + WORD_SAMP*k, (first_phase + k) % 4, 0);
        w.chan[1] = expected_chan(first_sample + WORD_SAMP*k, (first_phase + k) % 4, ch1_offset);
        return w;
    endfunction

    task automatic check_channels(input sample_buffer_pkg::mem_word_t w, input int k);
        for (int p = 0; p < WORD_SAMP; p++) begin
            check_value(w.chan[1][p*NBIT +: NBIT], NBIT'(w.chan[0][p*NBIT +: NBIT] + ch1_offset),
                        $sformatf("channel 1 offset, word %0d sample %0d", k, p));
        end
    endtask

    // memclk edge q sits at q periods from time 0
    task automatic wait_mem_edge(input int q);
        while ($time < q*MEMCLK_PERIOD) begin
            @(posedge memclk);
        end
        #DRIVE_DELAY;
    endtask

    initial begin : drive_samples
        wait (stim_loaded);
        #DRIVE_DELAY;
        dat_ch0 = ramp_word(0, 0);
        dat_ch1 = ramp_word(0, ch1_offset);
        for (int i = 1; i < aclk_words; i++) begin
            @(posedge aclk);
            #DRIVE_DELAY;
            dat_ch0 = ramp_word(i, 0);
            dat_ch1 = ramp_word(i, ch1_offset);
        end
    end

    initial begin : watchdog
        wait (stim_loaded);
        #((aclk_words + RAM_WORDS + 50) * ACLK_PERIOD);
        abort_run("timeout: the run did not finish within its time limit");
    end

    initial begin : run_tests
        int                                 trig_addr;
        int                                 waited;
        sample_buffer_pkg::capture_status_t held;
        load_stim();
        stim_loaded = 1'b1;
        // 8 aclk cycles, then let go so that 360 ns is the first edge out of reset
        repeat (8) @(posedge aclk);
        @(posedge memclk);
        #DRIVE_DELAY;
        rst = 1'b0;
        check_value(status, '0, "status after reset");

        wait_mem_edge(arm_cycle);
        arm = 1'b1;
        wait_mem_edge(arm_cycle + 1);
        arm = 1'b0;
        check_value(status.armed, 1'b1, "armed after arm strobe");
        wait_mem_edge(trig_cycle);
        trig = 1'b1;
        wait_mem_edge(trig_cycle + 1);
        trig = 1'b0;
        // first write lands two edges after arm is driven, at address 0
        trig_addr = trig_cycle - arm_cycle - 1;

        waited = 0;
        while (!status.done && waited < 2*`SB_POST_WORDS) begin
            @(posedge memclk);
            #DRIVE_DELAY;
            waited++;
        end
        if (!status.done) begin
            abort_run("done never rose after the trigger");
        end
        check_value(status.stop_addr, (trig_addr + `SB_POST_WORDS) % RAM_WORDS,
                    "stop address from trigger count");
        check_value(status.stop_addr, exp_stop, "stop address from stim file");
        check_value(status.armed, 1'b0, "armed cleared at done");

        // oldest word first, data one edge after the address
        rd_en = 1'b1;
        for (int k = 0; k <= RAM_WORDS; k++) begin
            if (k > 0) begin
                check_channels(rd_data, k - 1);
                check_value(rd_data, expected_word(k - 1), $sformatf("ram word %0d", k - 1));
            end
            if (k < RAM_WORDS) begin
                rd_addr = sample_buffer_pkg::addr_t'(status.stop_addr + k);
            end
            @(posedge memclk);
            #DRIVE_DELAY;
        end
        rd_en = 1'b0;

        // triggers in DONE leave status alone
        held = status;
        repeat (3) begin
            trig = 1'b1;
            @(posedge memclk);
            #DRIVE_DELAY;
            trig = 1'b0;
            @(posedge memclk);
            #DRIVE_DELAY;
            check_value(status, held, "status after trigger in DONE");
        end
        arm = 1'b1;
        @(posedge memclk);
        #DRIVE_DELAY;
        arm = 1'b0;
        check_value(status.done, 1'b0, "done after re-arm");
        check_value(status.armed, 1'b1, "armed after re-arm");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- sample_buffer_stim.txt
# aclk_words ramp_start ch1_offset(hex) arm_cycle trig_cycle  (cycles are memclk edges from time 0)
80 0 800 20 50
# stop_addr first_sample first_phase  (oldest ram word: first ramp index and its write phase)
5 130 2

//--- sample_buffer_top.f
+incdir+.
sample_buffer_pkg.sv
transfer_phase_timer.sv
uram_sync_transfer.sv
capture_fsm.sv
event_ram.sv
sample_buffer_top.sv
sample_buffer_tb.sv

//--- Bender.yml
package:
  name: sample_buffer

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - sample_buffer_pkg.sv
      - transfer_phase_timer.sv
      - uram_sync_transfer.sv
      - capture_fsm.sv
      - event_ram.sv
      - sample_buffer_top.sv
      - target: test
        files:
          - sample_buffer_tb.sv
